// ==== hdl/cpuCore_defs.svh ====
/*
  Core-wide widths, reset PC and the MIPS opcode and funct encodings.
  Include wherever a width or an instruction encoding is needed.
*/
`ifndef CPUCORE_DEFS_SVH
`define CPUCORE_DEFS_SVH

`define WORD_W     32
`define REG_ADDR_W 5
`define REG_COUNT  32
// Reset PC as a word address
`define PC_INIT    0

// Opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0A
`define OP_ANDI  6'h0C
`define OP_ORI   6'h0D
`define OP_XORI  6'h0E
`define OP_LUI   6'h0F
`define OP_LW    6'h23
`define OP_SW    6'h2B
`define OP_HALT  6'h3F

// R-type funct field
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_JR   6'h08
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_NOR  6'h27
`define FN_SLT  6'h2A
`define FN_SLTU 6'h2B

`endif

// ==== hdl/cpuTypesPkg.sv ====
/*
  Types shared across the core: vector typedefs, the ALU and memory
  controller enums, and the control and memory request/response structs.
*/
`include "cpuCore_defs.svh"

package cpuTypesPkg;

  typedef logic [`WORD_W-1:0]     word_t;
  typedef logic [`REG_ADDR_W-1:0] regbits_t;
  typedef logic [5:0]             opcode_t;
  typedef logic [5:0]             funct_t;

  typedef enum logic [3:0] {
    aluSll,
    aluSrl,
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluNor,
    aluSlt,
    aluSltu
  } aluOp_t;

  // Access the memory controller is currently serving
  typedef enum logic [1:0] {
    memIdle,
    memInstr,
    memData
  } memState_t;

  typedef struct packed {
    logic       regWr;
    logic       regDst;
    logic       aluSrc;
    logic       extOp;
    // 0 alu, 1 pc+4, 2 load, 3 upper imm
    logic [1:0] memToReg;
    // 0 sequential or branch, 1 jump, 2 register
    logic [1:0] jumpSel;
    logic       beq;
    logic       bne;
    logic       jal;
    logic       dREN;
    logic       dWEN;
    logic       halt;
    aluOp_t     aluOp;
  } ctrl_t;

  typedef struct packed {
    logic  iREN;
    logic  dREN;
    logic  dWEN;
    word_t iAddr;
    word_t dAddr;
    word_t dStore;
  } memReq_t;

  typedef struct packed {
    logic  ihit;
    logic  dhit;
    word_t iLoad;
    word_t dLoad;
  } memRsp_t;

endpackage

// ==== hdl/controlUnit.sv ====
/*
  Instruction decoder. Turns opcode and funct into the control struct
  read by the datapath; unknown codes decode to a harmless no-op.
*/
`include "cpuCore_defs.svh"

module controlUnit
  import cpuTypesPkg::*;
(
  input  opcode_t opcode,
  input  funct_t  funct,
  output ctrl_t   ctrl
);

  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = aluAdd;
    case (opcode)
      `OP_RTYPE: begin
        ctrl.regWr  = 1'b1;
        ctrl.regDst = 1'b1;
        case (funct)
          `FN_SLL:  ctrl.aluOp = aluSll;
          `FN_SRL:  ctrl.aluOp = aluSrl;
          `FN_ADDU: ctrl.aluOp = aluAdd;
          `FN_SUBU: ctrl.aluOp = aluSub;
          `FN_AND:  ctrl.aluOp = aluAnd;
          `FN_OR:   ctrl.aluOp = aluOr;
          `FN_XOR:  ctrl.aluOp = aluXor;
          `FN_NOR:  ctrl.aluOp = aluNor;
          `FN_SLT:  ctrl.aluOp = aluSlt;
          `FN_SLTU: ctrl.aluOp = aluSltu;
          `FN_JR: begin
            ctrl.regWr   = 1'b0;
            ctrl.jumpSel = 2'd2;
          end
          default:  ctrl.regWr = 1'b0;
        endcase
      end
      `OP_ADDIU, `OP_SLTI: begin
        ctrl.regWr  = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.extOp  = 1'b1;
        ctrl.aluOp  = (opcode == `OP_SLTI) ? aluSlt : aluAdd;
      end
      `OP_ANDI: begin
        ctrl.regWr  = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = aluAnd;
      end
      `OP_ORI: begin
        ctrl.regWr  = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = aluOr;
      end
      `OP_XORI: begin
        ctrl.regWr  = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = aluXor;
      end
      `OP_LUI: begin
        ctrl.regWr    = 1'b1;
        ctrl.memToReg = 2'd3;
      end
      `OP_LW: begin
        ctrl.regWr    = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.extOp    = 1'b1;
        ctrl.memToReg = 2'd2;
        ctrl.dREN     = 1'b1;
      end
      `OP_SW: begin
        ctrl.aluSrc = 1'b1;
        ctrl.extOp  = 1'b1;
        ctrl.dWEN   = 1'b1;
      end
      // Compare by subtraction, offset is sign extended
      `OP_BEQ, `OP_BNE: begin
        ctrl.extOp = 1'b1;
        ctrl.aluOp = aluSub;
        ctrl.beq   = (opcode == `OP_BEQ);
        ctrl.bne   = (opcode == `OP_BNE);
      end
      `OP_J: ctrl.jumpSel = 2'd1;
      `OP_JAL: begin
        ctrl.jumpSel  = 2'd1;
        ctrl.jal      = 1'b1;
        ctrl.regWr    = 1'b1;
        ctrl.memToReg = 2'd1;
      end
      `OP_HALT: ctrl.halt = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== hdl/alu.sv ====
/*
  Combinational ALU. Shifts take the amount from the low bits of portA
  and shift portB; zero flags an all-zero result for branch compares.
*/
module alu
  import cpuTypesPkg::*;
(
  input  aluOp_t aluOp,
  input  word_t  portA,
  input  word_t  portB,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (aluOp)
      aluSll:  result = portB << portA[4:0];
      aluSrl:  result = portB >> portA[4:0];
      aluAdd:  result = portA + portB;
      aluSub:  result = portA - portB;
      aluAnd:  result = portA & portB;
      aluOr:   result = portA | portB;
      aluXor:  result = portA ^ portB;
      aluNor:  result = ~(portA | portB);
      aluSlt:  result = word_t'($signed(portA) < $signed(portB));
      aluSltu: result = word_t'(portA < portB);
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

// ==== hdl/registerFile.sv ====
/*
  General purpose registers. Two combinational read ports and one
  write port that updates at the clock edge; register 0 stays zero.
*/
`include "cpuCore_defs.svh"

module registerFile
  import cpuTypesPkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wen,
  input  regbits_t wsel,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  input  word_t    wdat,
  output word_t    rdat1,
  output word_t    rdat2
);

  word_t regs [`REG_COUNT];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != '0)) begin
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

// ==== hdl/requestUnit.sv ====
/*
  Data request gate. Passes the decoded load/store request through
  until its dhit, then blocks it until the instruction retires on ihit.
*/
module requestUnit (
  input  logic CLK,
  input  logic nRST,
  input  logic ihit,
  input  logic dhit,
  input  logic dREN,
  input  logic dWEN,
  output logic dmemREN,
  output logic dmemWEN
);

  // Set once the current instruction's data access is done
  logic served;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      served <= 1'b0;
    end else if (dhit) begin
      served <= 1'b1;
    end else if (ihit) begin
      served <= 1'b0;
    end
  end

  assign dmemREN = dREN & ~served;
  assign dmemWEN = dWEN & ~served;

endmodule

// ==== hdl/datapath.sv ====
/*
  Single-cycle datapath. Splits the instruction, builds immediates and
  branch/jump targets, keeps the PC and halt state, and issues memory
  requests; PC and register writes advance only on ihit.
*/
`include "cpuCore_defs.svh"

module datapath
  import cpuTypesPkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  memRsp_t rsp,
  output memReq_t req,
  output logic    halt
);

  ctrl_t      ctrl;
  word_t      instr;
  opcode_t    opcode;
  funct_t     funct;
  regbits_t   rs, rt, rd;
  logic [4:0] shamt;
  logic [15:0] imm;

  word_t    pc, pcPlus4, nextPc;
  word_t    extImm, branchTarget, jumpTarget;
  word_t    aluA, aluB, aluResult;
  logic     aluZero, shiftOp, takeBranch;
  word_t    rdat1, rdat2, wdat;
  regbits_t wsel;
  logic     regWen;
  logic     dmemREN, dmemWEN;

  // Instruction fields
  assign instr  = rsp.iLoad;
  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign shamt  = instr[10:6];
  assign funct  = instr[5:0];
  assign imm    = instr[15:0];

  controlUnit i_controlUnit (.opcode, .funct, .ctrl);

  assign extImm = ctrl.extOp ? {{16{imm[15]}}, imm} : {16'h0000, imm};

  // Shift amount comes from the instruction, not rs
  assign shiftOp = (ctrl.aluOp == aluSll) || (ctrl.aluOp == aluSrl);
  assign aluA    = shiftOp ? word_t'(shamt) : rdat1;
  assign aluB    = ctrl.aluSrc ? extImm : rdat2;

  alu i_alu (
    .aluOp  (ctrl.aluOp),
    .portA  (aluA),
    .portB  (aluB),
    .result (aluResult),
    .zero   (aluZero)
  );

  // Next PC
  assign pcPlus4      = pc + word_t'(4);
  assign branchTarget = pcPlus4 + {extImm[29:0], 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};
  assign takeBranch   = (ctrl.beq & aluZero) | (ctrl.bne & ~aluZero);

  always_comb begin
    case (ctrl.jumpSel)
      2'd1:    nextPc = jumpTarget;
      2'd2:    nextPc = rdat1;
      default: nextPc = takeBranch ? branchTarget : pcPlus4;
    endcase
  end

  // Write-back
  always_comb begin
    if (ctrl.jal) begin
      wsel = regbits_t'(31);
    end else if (ctrl.regDst) begin
      wsel = rd;
    end else begin
      wsel = rt;
    end
    case (ctrl.memToReg)
      2'd0: wdat = aluResult;
      2'd1: wdat = pcPlus4;
      2'd2: wdat = rsp.dLoad;
      default: wdat = {imm, 16'h0000};
    endcase
  end

  assign regWen = ctrl.regWr & rsp.ihit;

  registerFile i_registerFile (
    .CLK, .nRST,
    .wen   (regWen),
    .wsel,
    .rsel1 (rs),
    .rsel2 (rt),
    .wdat,
    .rdat1,
    .rdat2
  );

  requestUnit i_requestUnit (
    .CLK, .nRST,
    .ihit (rsp.ihit),
    .dhit (rsp.dhit),
    .dREN (ctrl.dREN),
    .dWEN (ctrl.dWEN),
    .dmemREN,
    .dmemWEN
  );

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= word_t'(`PC_INIT) << 2;
    end else if (rsp.ihit) begin
      pc <= nextPc;
    end
  end

  // Sticky once HALT retires
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (rsp.ihit && ctrl.halt) begin
      halt <= 1'b1;
    end
  end

  always_comb begin
    req.iREN   = ~halt;
    req.dREN   = dmemREN;
    req.dWEN   = dmemWEN;
    req.iAddr  = pc;
    req.dAddr  = aluResult;
    req.dStore = rdat2;
  end

endmodule

// ==== hdl/memoryControl.sv ====
/*
  Single-port RAM arbiter. A fetched word gets one cycle to raise a data
  request, which then wins over the next fetch; a load or store is
  fetched again after its dhit. ramAddr is a word address.
*/
`include "cpuCore_defs.svh"

module memoryControl
  import cpuTypesPkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  memReq_t req,
  output memRsp_t rsp,
  output logic    ramREN,
  output logic    ramWEN,
  output word_t   ramAddr,
  output word_t   ramStore,
  input  word_t   ramLoad,
  input  logic    ramReady
);

  memState_t state, access;
  logic      fetched, dhitReg, dataPending;
  word_t     iLoadReg, dLoadReg;

  assign dataPending = req.dREN | req.dWEN;

  // Idle starts a new access in the same cycle, otherwise the current one holds
  always_comb begin
    access = state;
    if (state == memIdle) begin
      if (fetched && dataPending) begin
        access = memData;
      end else if (!fetched && !dhitReg && req.iREN) begin
        access = memInstr;
      end
    end
  end

  assign ramREN   = (access == memInstr) | ((access == memData) & req.dREN);
  assign ramWEN   = (access == memData) & req.dWEN;
  assign ramAddr  = (access == memData) ? word_t'(req.dAddr[`WORD_W-1:2])
                                        : word_t'(req.iAddr[`WORD_W-1:2]);
  assign ramStore = req.dStore;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= memIdle;
      fetched  <= 1'b0;
      dhitReg  <= 1'b0;
      iLoadReg <= '0;
    end else begin
      fetched <= 1'b0;
      dhitReg <= 1'b0;
      if ((access != memIdle) && ramReady) begin
        state   <= memIdle;
        fetched <= (access == memInstr);
        dhitReg <= (access == memData);
        if (access == memInstr) begin
          iLoadReg <= ramLoad;
        end
      end else begin
        state <= access;
      end
      // A retired instruction leaves a NOP until the next fetch lands
      if (rsp.ihit) begin
        iLoadReg <= '0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if ((access == memData) && ramReady && req.dREN) begin
      dLoadReg <= ramLoad;
    end
  end

  always_comb begin
    rsp.ihit  = fetched & ~dataPending;
    rsp.dhit  = dhitReg;
    rsp.iLoad = iLoadReg;
    rsp.dLoad = dLoadReg;
  end

endmodule

// ==== hdl/cpuCore.sv ====
/*
  Processor top level. Joins the datapath to the memory controller and
  exposes the single RAM port and the halt flag.
*/
module cpuCore
  import cpuTypesPkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  output logic  halt,
  output logic  ramREN,
  output logic  ramWEN,
  output word_t ramAddr,
  output word_t ramStore,
  input  word_t ramLoad,
  input  logic  ramReady
);

  memReq_t req;
  memRsp_t rsp;

  datapath i_datapath (.CLK, .nRST, .rsp, .req, .halt);

  memoryControl i_memoryControl (
    .CLK, .nRST,
    .req, .rsp,
    .ramREN, .ramWEN,
    .ramAddr, .ramStore,
    .ramLoad, .ramReady
  );

endmodule

// ==== test/ramModel.sv ====
/*
  Behavioral word-addressed RAM for the testbench. Loads the program
  image during reset and answers each access after 0 to 3 wait cycles
  drawn from an LCG.
*/
module ramModel
  import cpuTypesPkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  word_t image [1024],
  input  logic  ramREN,
  input  logic  ramWEN,
  input  word_t ramAddr,
  input  word_t ramStore,
  output word_t ramLoad,
  output logic  ramReady
);

  word_t      mem [1024];
  logic [1:0] waitCnt;
  logic [31:0] lcgState;

  function automatic logic [31:0] nextLcg(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  assign ramReady = (ramREN | ramWEN) && (waitCnt == 2'd0);
  assign ramLoad  = mem[ramAddr[9:0]];

  always @(posedge CLK, negedge nRST) begin
    logic [31:0] draw;
    if (!nRST) begin
      mem      <= image;
      lcgState <= 32'h276f_8498;
      waitCnt  <= 2'd1;
    end else if (ramREN | ramWEN) begin
      if (waitCnt != 2'd0) begin
        waitCnt <= waitCnt - 2'd1;
      end else begin
        // Access completes, pick the latency of the next one
        draw = nextLcg(lcgState);
        lcgState <= draw;
        waitCnt  <= draw[17:16];
        if (ramWEN) begin
          mem[ramAddr[9:0]] <= ramStore;
        end
      end
    end
  end

endmodule

// ==== test/cpuCoreTb.sv ====
/*
  Testbench for the core. Builds one program that stores every result
  to its own slot, runs it to HALT and checks the slots and bus traffic.
*/
`include "cpuCore_defs.svh"

module cpuCoreTb
  import cpuTypesPkg::*;
;

  localparam int RES_BASE = 256;
  localparam int NSLOT    = 32;
  localparam int TIMEOUT  = 20000;

  logic  CLK;
  logic  nRST;
  logic  halt, ramREN, ramWEN, ramReady;
  word_t ramAddr, ramStore, ramLoad;
  word_t image [1024];

  int   mismatchCount, failCount, progLen, jalAddr;
  int   monitorFails = 0;
  logic haltSeen = 1'b0;

  cpuCore i_dut (
    .CLK, .nRST, .halt,
    .ramREN, .ramWEN, .ramAddr, .ramStore,
    .ramLoad, .ramReady
  );

  ramModel i_ram (
    .CLK, .nRST, .image,
    .ramREN, .ramWEN, .ramAddr, .ramStore,
    .ramLoad, .ramReady
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic word_t fillWord(input logic [31:0] a);
    return {a[15:0] ^ 16'h5A5A, ~a[15:0]};
  endfunction

  function automatic word_t rType(input logic [4:0] rs, input logic [4:0] rt,
                                  input logic [4:0] rd, input logic [4:0] sh,
                                  input logic [5:0] fn);
    return {`OP_RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t iType(input logic [5:0] op, input logic [4:0] rs,
                                  input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jType(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic emit(input word_t w);
    image[progLen] = w;
    progLen++;
  endtask

  // Store a register into result slot n relative to the base in r1
  task automatic storeSlot(input logic [4:0] rt, input int n);
    emit(iType(`OP_SW, 5'd1, rt, 16'(n * 4)));
  endtask

  task automatic buildProgram();
    logic [4:0] srcReg [18];
    srcReg = '{5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10,
               5'd11, 5'd13, 5'd14, 5'd15, 5'd16, 5'd17, 5'd18, 5'd19, 5'd0};
    for (int i = 0; i < 1024; i++) begin
      image[i] = fillWord(32'(i));
    end
    progLen = 0;
    emit(iType(`OP_ADDIU, 5'd0, 5'd1, 16'h0400));
    emit(iType(`OP_LUI, 5'd0, 5'd2, 16'h8000));
    emit(iType(`OP_ORI, 5'd2, 5'd2, 16'h1234));
    emit(iType(`OP_ADDIU, 5'd0, 5'd3, 16'hFFFB));
    emit(rType(5'd2, 5'd3, 5'd4, 5'd0, `FN_ADDU));
    emit(rType(5'd3, 5'd2, 5'd5, 5'd0, `FN_SUBU));
    emit(rType(5'd2, 5'd3, 5'd6, 5'd0, `FN_AND));
    emit(rType(5'd2, 5'd3, 5'd7, 5'd0, `FN_OR));
    emit(rType(5'd2, 5'd3, 5'd8, 5'd0, `FN_XOR));
    emit(rType(5'd2, 5'd3, 5'd9, 5'd0, `FN_NOR));
    emit(rType(5'd2, 5'd3, 5'd10, 5'd0, `FN_SLT));
    emit(rType(5'd3, 5'd2, 5'd11, 5'd0, `FN_SLTU));
    emit(rType(5'd0, 5'd2, 5'd13, 5'd4, `FN_SLL));
    emit(rType(5'd0, 5'd2, 5'd14, 5'd28, `FN_SRL));
    emit(iType(`OP_ANDI, 5'd3, 5'd15, 16'h8F0F));
    emit(iType(`OP_ORI, 5'd0, 5'd16, 16'h8001));
    emit(iType(`OP_SLTI, 5'd3, 5'd17, 16'hFFFC));
    emit(iType(`OP_XORI, 5'd2, 5'd18, 16'hFFFF));
    emit(iType(`OP_ADDIU, 5'd2, 5'd19, 16'h8000));
    emit(iType(`OP_ADDIU, 5'd0, 5'd0, 16'h0055));
    emit(iType(`OP_ADDIU, 5'd0, 5'd21, 16'h00AB));
    for (int i = 0; i < 18; i++) begin
      storeSlot(srcReg[i], i);
    end
    // Load back a stored word
    storeSlot(5'd2, 18);
    emit(iType(`OP_LW, 5'd1, 5'd20, 16'(18 * 4)));
    emit(iType(`OP_ADDIU, 5'd20, 5'd20, 16'h0001));
    storeSlot(5'd20, 19);
    // Branches skip one instruction when taken
    emit(iType(`OP_BEQ, 5'd3, 5'd3, 16'd1));
    storeSlot(5'd7, 20);
    storeSlot(5'd21, 21);
    emit(iType(`OP_BEQ, 5'd3, 5'd2, 16'd1));
    storeSlot(5'd21, 22);
    emit(iType(`OP_BNE, 5'd3, 5'd2, 16'd1));
    storeSlot(5'd7, 23);
    storeSlot(5'd21, 24);
    emit(iType(`OP_BNE, 5'd3, 5'd3, 16'd1));
    storeSlot(5'd21, 25);
    emit(jType(`OP_J, 26'(progLen + 2)));
    storeSlot(5'd7, 26);
    storeSlot(5'd21, 27);
    // Subroutine past HALT returns to the marker store
    jalAddr = progLen;
    emit(jType(`OP_JAL, 26'(progLen + 3)));
    storeSlot(5'd21, 29);
    emit({`OP_HALT, 26'd0});
    storeSlot(5'd31, 28);
    emit(rType(5'd31, 5'd0, 5'd0, 5'd0, `FN_JR));
  endtask

  task automatic checkSlot(input string name, input int n, input word_t expected);
    word_t actual;
    actual = i_ram.mem[RES_BASE + n];
    assert (actual === expected) else begin
      mismatchCount++;
      $display("mismatch %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  // Bus and halt monitor
  always @(negedge CLK) begin
    if (nRST) begin
      if (halt) begin
        haltSeen = 1'b1;
      end
      if (haltSeen) begin
        assert (halt) else begin
          monitorFails++;
          $display("halt dropped after it had risen at %0t", $time);
        end
        assert (!ramWEN) else begin
          monitorFails++;
          $display("RAM write after halt at %0t", $time);
        end
        assert (!ramREN) else begin
          monitorFails++;
          $display("RAM read after halt at %0t", $time);
        end
      end
      if (ramWEN) begin
        assert (ramAddr >= 32'(RES_BASE) && ramAddr < 32'(RES_BASE + NSLOT)) else begin
          monitorFails++;
          $display("RAM write outside the result area at word %h", ramAddr);
        end
      end
    end
  end

  initial begin
    word_t vA, vB, marker;
    int    cycles;
    nRST          = 1'b0;
    mismatchCount = 0;
    failCount     = 0;
    buildProgram();
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;

    cycles = 0;
    while (!halt && cycles < TIMEOUT) begin
      @(posedge CLK);
      cycles++;
    end
    assert (halt) else begin
      failCount++;
      $display("timeout: halt did not rise within %0d cycles", TIMEOUT);
    end
    // Watch the bus for a while after halt
    repeat (20) @(posedge CLK);

    vA     = 32'h8000_1234;
    vB     = 32'hFFFF_FFFB;
    marker = 32'h0000_00AB;
    checkSlot("luiOri", 0, vA);
    checkSlot("addiuNeg", 1, vB);
    checkSlot("addu", 2, vA + vB);
    checkSlot("subu", 3, vB - vA);
    checkSlot("and", 4, vA & vB);
    checkSlot("or", 5, vA | vB);
    checkSlot("xor", 6, vA ^ vB);
    checkSlot("nor", 7, ~(vA | vB));
    // vA is near the most negative value, so it is below -5
    checkSlot("sltSigned", 8, 32'd1);
    // Unsigned, 0xFFFFFFFB is above 0x80001234
    checkSlot("sltuUnsigned", 9, 32'd0);
    checkSlot("sll", 10, vA << 4);
    checkSlot("srl", 11, vA >> 28);
    checkSlot("andiZeroExt", 12, vB & 32'h0000_8F0F);
    checkSlot("oriZeroExt", 13, 32'h0000_8001);
    // -5 is below the sign-extended -4
    checkSlot("sltiSignExt", 14, 32'd1);
    checkSlot("xoriZeroExt", 15, vA ^ 32'h0000_FFFF);
    checkSlot("addiuSignExt", 16, vA + 32'hFFFF_8000);
    checkSlot("regZero", 17, 32'd0);
    checkSlot("storeWord", 18, vA);
    checkSlot("loadAfterStore", 19, vA + 32'd1);
    checkSlot("beqTakenSkipped", 20, fillWord(32'(RES_BASE + 20)));
    checkSlot("beqTaken", 21, marker);
    checkSlot("beqNotTaken", 22, marker);
    checkSlot("bneTakenSkipped", 23, fillWord(32'(RES_BASE + 23)));
    checkSlot("bneTaken", 24, marker);
    checkSlot("bneNotTaken", 25, marker);
    checkSlot("jSkipped", 26, fillWord(32'(RES_BASE + 26)));
    checkSlot("jTaken", 27, marker);
    checkSlot("jalLink", 28, 32'(jalAddr * 4 + 4));
    checkSlot("jrReturn", 29, marker);

    failCount += monitorFails;
    $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
    if (mismatchCount == 0 && failCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== cpuCore.f ====
+incdir+hdl
hdl/cpuTypesPkg.sv
hdl/controlUnit.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/requestUnit.sv
hdl/datapath.sv
hdl/memoryControl.sv
hdl/cpuCore.sv
test/ramModel.sv
test/cpuCoreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the core and its testbench with Verilator, runs the simulation
# and decides the result from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
  --top-module cpuCoreTb \
  -f cpuCore.f \
  -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/VcpuCoreTb > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see $SIM_LOG"
  exit 1
fi

if grep -q ">>> FAIL" "$SIM_LOG"; then
  echo "Simulation reported failure, see $SIM_LOG"
  exit 1
fi

echo "Simulation passed"
exit 0
